//--- verilog/qa_pkg.sv
package qa_pkg;

   // ======================================================================
   // Line and field geometry
   // ======================================================================

   // Cache-line address width, in units of whole lines
   localparam int addr_width = 32;

   // One cache line is sixteen 32-bit words
   localparam int line_width = 512;
   localparam int word_width = 32;
   localparam int line_words = line_width / word_width;

   // Default width of the programmed stream length
   localparam int len_width = 16;

   // First word of the identification line, words 1 to 3 count up from it
   localparam logic [word_width-1:0] afu_id_base = 32'haced0000;

   // ======================================================================
   // Encodings
   // ======================================================================

   // Host register addresses
   typedef enum logic [2:0] {
      csr_dsm_base,
      csr_stream_base,
      csr_stream_len,
      csr_start,
      csr_trigger_debug
   } csr_addr_e;

   // Channel request types; the engine only ever issues full line writes
   typedef enum logic [1:0] {
      wr_line,
      wr_fence
   } req_type_e;

   // ======================================================================
   // Structures shared between the blocks
   // ======================================================================

   // Registered host-visible state, start and trigger_debug last one cycle
   typedef struct packed {
      logic [addr_width-1:0] dsm_base;
      logic                  dsm_base_valid;
      logic [addr_width-1:0] stream_base;
      logic [len_width-1:0]  stream_len;
      logic                  start;
      logic [7:0]            trigger_debug;
   } csr_state_t;

   typedef struct packed {
      req_type_e             req_type;
      logic [addr_width-1:0] address;
   } write_header_t;

   // One requester's offer to the arbiter
   typedef struct packed {
      logic                  request;
      write_header_t         write_header;
      logic [line_width-1:0] data;
   } frame_arb_t;

   typedef struct packed {
      logic status_grant;
      logic stream_grant;
   } channel_grant_t;

   // Registered write channel output
   typedef struct packed {
      logic                  valid;
      write_header_t         write_header;
      logic [line_width-1:0] data;
   } tx_req_t;

   // Debug word dumped by the stream generator on request
   typedef struct packed {
      logic [31:0] lines_written;
      logic [15:0] stream_len;
      logic [15:0] reserved;
   } debug_rsp_t;

endpackage

//--- verilog/qa_csr.sv
module qa_csr #(
   parameter int len_bits = qa_pkg::len_width
) (
   input  logic                clk,
   input  logic                resetb,

   // Host register write port
   input  logic                csr_write,
   input  qa_pkg::csr_addr_e   csr_addr,
   input  logic [31:0]         csr_data,

   output qa_pkg::csr_state_t  csr
);

   import qa_pkg::*;

   // Stream length as written by the host, widened to the shared field
   logic [len_width-1:0] len_wr;

   // Only the low len_bits of the written value are kept
   assign len_wr = len_width'(csr_data[len_bits-1:0]);

   // ======================================================================
   // Register write decode
   // ======================================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         csr <= '0;
      end else begin
         // Strobes drop back to zero unless written again this cycle
         csr.start         <= 1'b0;
         csr.trigger_debug <= '0;

         if (csr_write) begin
            case (csr_addr)
               csr_dsm_base: begin
                  // A DSM base write is what lets the engine announce itself
                  csr.dsm_base       <= csr_data[addr_width-1:0];
                  csr.dsm_base_valid <= 1'b1;
               end
               csr_stream_base: begin
                  csr.stream_base <= csr_data[addr_width-1:0];
               end
               csr_stream_len: begin
                  csr.stream_len <= len_wr;
               end
               csr_start: begin
                  // Single-cycle start pulse, the data value is not used
                  csr.start <= 1'b1;
               end
               csr_trigger_debug: begin
                  // Debug index sits in the low byte; zero means no request
                  csr.trigger_debug <= csr_data[7:0];
               end
               default: begin
                  // Unknown addresses are dropped
               end
            endcase
         end
      end
   end

endmodule

//--- verilog/status_writer.sv
module status_writer (
   input  logic                  clk,
   input  logic                  resetb,

   input  qa_pkg::csr_state_t    csr,
   output qa_pkg::frame_arb_t    status_writer,
   input  qa_pkg::channel_grant_t write_grant,

   // Debug word and completion level from the stream generator
   input  qa_pkg::debug_rsp_t    dbg_stream,
   input  logic                  stream_done,
   output logic                  stream_run
);

   import qa_pkg::*;

   typedef enum logic [2:0] {
      st_init,
      st_idle,
      st_run,
      st_debug,
      st_done
   } state_e;

   state_e state;
   state_e next_state;

   // Index of the debug request being served
   logic [7:0] debug_idx;

   // Candidate line contents, one per writing state
   logic [line_width-1:0] id_line;
   logic [line_width-1:0] debug_line;
   logic [line_width-1:0] done_line;

   // A start is only honoured with something to stream
   logic run_start;

   assign run_start = csr.start && (csr.stream_len != '0);

   // ======================================================================
   // Line contents
   // ======================================================================

   // ID line tells the host the engine is alive
   always_comb begin
      id_line = '0;
      for (int i = 0; i < 4; i++) begin
         id_line[i*word_width +: word_width] = afu_id_base + word_width'(i);
      end
   end

   // The index sits in the top word so the host can match the reply
   always_comb begin
      debug_line = '0;
      debug_line[(line_words-1)*word_width +: word_width] = word_width'(debug_idx);
      // Index 1 selects the stream generator, others return only the index
      if (debug_idx == 8'd1) begin
         debug_line[$bits(debug_rsp_t)-1:0] = dbg_stream;
      end
   end

   // Completion flag in word 0, line count in word 1
   always_comb begin
      done_line = '0;
      done_line[0 +: word_width]          = word_width'(1);
      done_line[word_width +: word_width] = dbg_stream.lines_written;
   end

   // ======================================================================
   // FSM
   // ======================================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= st_init;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         st_init, st_debug, st_done: begin
            // Each writing state lasts until its one line is granted
            if (write_grant.status_grant) begin
               next_state = st_idle;
            end
         end
         st_idle: begin
            // Start wins over a debug trigger arriving in the same cycle
            if (run_start) begin
               next_state = st_run;
            end else if (csr.trigger_debug != '0) begin
               next_state = st_debug;
            end
         end
         st_run: begin
            if (stream_done) begin
               next_state = st_done;
            end
         end
         default: begin
            next_state = st_init;
         end
      endcase
   end

   // Capture the index only when the trigger is accepted
   always_ff @(posedge clk) begin
      if (state == st_idle && next_state == st_debug) begin
         debug_idx <= csr.trigger_debug;
      end
   end

   assign stream_run = (state == st_run);

   // ======================================================================
   // Request to the arbiter
   // ======================================================================

   always_comb begin
      status_writer.request = csr.dsm_base_valid &&
         (state == st_init || state == st_debug || state == st_done);
      status_writer.write_header.req_type = wr_line;
      // Completion goes to DSM line 1, everything else to line 0
      if (state == st_done) begin
         status_writer.write_header.address = csr.dsm_base + addr_width'(1);
      end else begin
         status_writer.write_header.address = csr.dsm_base;
      end
      case (state)
         st_debug: status_writer.data = debug_line;
         st_done:  status_writer.data = done_line;
         default:  status_writer.data = id_line;
      endcase
   end

endmodule

//--- verilog/stream_writer.sv
module stream_writer #(
   parameter int len_bits = qa_pkg::len_width
) (
   input  logic                   clk,
   input  logic                   resetb,

   input  qa_pkg::csr_state_t     csr,
   input  logic                   stream_run,
   output qa_pkg::frame_arb_t     stream_writer,
   input  qa_pkg::channel_grant_t write_grant,

   output logic                   stream_done,
   output qa_pkg::debug_rsp_t     dbg_stream
);

   import qa_pkg::*;

   // Index of the next line, which is also the count of granted lines
   logic [len_bits-1:0] line_cnt;

   // Programmed length cut to the counter width
   logic [len_bits-1:0] run_len;

   // Value written into every word of the current line
   logic [word_width-1:0] line_word;

   assign run_len   = csr.stream_len[len_bits-1:0];
   assign line_word = word_width'(line_cnt);

   // ======================================================================
   // Line counter
   // ======================================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         line_cnt <= '0;
      end else if (csr.start && !stream_run) begin
         // A fresh run starts from line zero
         // A start seen while running is ignored, as in the control FSM
         line_cnt <= '0;
      end else if (write_grant.stream_grant) begin
         line_cnt <= line_cnt + 1'b1;
      end
   end

   // Level, stays high between runs until the next start clears the count
   assign stream_done = (line_cnt == run_len);

   // ======================================================================
   // Request to the arbiter
   // ======================================================================

   always_comb begin
      // Request is steady until granted because the count only moves on grant
      stream_writer.request               = stream_run && !stream_done;
      stream_writer.write_header.req_type = wr_line;
      stream_writer.write_header.address  = csr.stream_base + addr_width'(line_cnt);
      // Every word carries the line index, which makes ordering easy to check
      stream_writer.data                  = {line_words{line_word}};
   end

   // ======================================================================
   // Debug word
   // ======================================================================

   // The count holds after a run so a later dump still sees it
   always_comb begin
      dbg_stream.lines_written = 32'(line_cnt);
      dbg_stream.stream_len    = csr.stream_len;
      dbg_stream.reserved      = '0;
   end

endmodule

//--- verilog/tx_write_arbiter.sv
module tx_write_arbiter (
   input  logic                   clk,
   input  logic                   resetb,

   input  qa_pkg::frame_arb_t     status_writer,
   input  qa_pkg::frame_arb_t     stream_writer,
   input  logic                   tx_almost_full,

   output qa_pkg::channel_grant_t write_grant,
   output qa_pkg::tx_req_t        tx_req
);

   import qa_pkg::*;

   // Frame picked this cycle
   frame_arb_t sel_frame;

   // Registered channel fields
   logic                  valid_q;
   write_header_t         header_q;
   logic [line_width-1:0] data_q;

   // Status lines are rare and short, so they always go first
   // Nothing is granted while the channel is almost full; requests just wait
   assign write_grant.status_grant = !tx_almost_full && status_writer.request;
   assign write_grant.stream_grant = !tx_almost_full && stream_writer.request &&
                                     !status_writer.request;

   assign sel_frame = write_grant.status_grant ? status_writer : stream_writer;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         valid_q <= 1'b0;
      end else begin
         // Exactly one cycle of valid per grant
         valid_q <= write_grant.status_grant || write_grant.stream_grant;
      end
   end

   always_ff @(posedge clk) begin
      header_q.req_type <= wr_line;
      header_q.address  <= sel_frame.write_header.address;
      data_q            <= sel_frame.data;
   end

   assign tx_req = '{valid: valid_q, write_header: header_q, data: data_q};

endmodule

//--- verilog/qa_afu_top.sv
module qa_afu_top #(
   parameter int len_bits = qa_pkg::len_width
) (
   input  logic               clk,
   input  logic               resetb,

   // Host register write port
   input  logic               csr_write,
   input  qa_pkg::csr_addr_e  csr_addr,
   input  logic [31:0]        csr_data,

   // Write channel to host memory
   input  logic               tx_almost_full,
   output qa_pkg::tx_req_t    tx_req
);

   import qa_pkg::*;

   csr_state_t     csr;
   frame_arb_t     status_frame;
   frame_arb_t     stream_frame;
   channel_grant_t write_grant;
   debug_rsp_t     dbg_stream;
   logic           stream_done;
   logic           stream_run;

   // ======================================================================
   // Control path
   // ======================================================================

   qa_csr #(
      .len_bits (len_bits)
   ) qa_csr_inst (
      .clk       (clk),
      .resetb    (resetb),
      .csr_write (csr_write),
      .csr_addr  (csr_addr),
      .csr_data  (csr_data),
      .csr       (csr)
   );

   status_writer status_writer_inst (
      .clk           (clk),
      .resetb        (resetb),
      .csr           (csr),
      .status_writer (status_frame),
      .write_grant   (write_grant),
      .dbg_stream    (dbg_stream),
      .stream_done   (stream_done),
      .stream_run    (stream_run)
   );

   // ======================================================================
   // Data path
   // ======================================================================

   stream_writer #(
      .len_bits (len_bits)
   ) stream_writer_inst (
      .clk           (clk),
      .resetb        (resetb),
      .csr           (csr),
      .stream_run    (stream_run),
      .stream_writer (stream_frame),
      .write_grant   (write_grant),
      .stream_done   (stream_done),
      .dbg_stream    (dbg_stream)
   );

   // Both requesters share the one write channel
   tx_write_arbiter tx_write_arbiter_inst (
      .clk            (clk),
      .resetb         (resetb),
      .status_writer  (status_frame),
      .stream_writer  (stream_frame),
      .tx_almost_full (tx_almost_full),
      .write_grant    (write_grant),
      .tx_req         (tx_req)
   );

endmodule

//--- test/tb_clock.sv
module tb_clock #(
   parameter int period = 20
) (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free-running clock, low for the first half period
   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule

//--- test/qa_afu_tb.sv
module qa_afu_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import qa_pkg::*;

   localparam int clk_period = 20;
   localparam int num_tests  = 6;
   // Longest wait in cycles for one expected frame
   localparam int frame_wait = 100;

   logic        clk;
   logic        resetb;
   logic        csr_write;
   csr_addr_e   csr_addr;
   logic [31:0] csr_data;
   logic        tx_almost_full;
   tx_req_t     tx_req;

   // Every frame seen on the channel, oldest first
   tx_req_t     frames[$];
   logic        bp_on;
   logic        af_last;
   int          errors;
   int          checks;
   int          len_a;
   int          len_b;
   int          len_c;
   int          len_d;
   int          budget;
   logic [31:0] dsm_base;
   logic [31:0] stream_base;

   tb_clock #(.period(clk_period)) tb_clock_inst (.clk(clk));

   qa_afu_top #(
      .len_bits (len_width)
   ) qa_afu_top_inst (
      .clk            (clk),
      .resetb         (resetb),
      .csr_write      (csr_write),
      .csr_addr       (csr_addr),
      .csr_data       (csr_data),
      .tx_almost_full (tx_almost_full),
      .tx_req         (tx_req)
   );

   // ======================================================================
   // Channel monitor and back-pressure source
   // ======================================================================

   // Valid in this cycle means a grant in the previous one, when af_last held
   always @(posedge clk) begin
      if (resetb && tx_req.valid) begin
         frames.push_back(tx_req);
         checks++;
         assert (!af_last) else begin
            errors++;
            $display("ERROR at %0t: tx_req.valid expected 0, got 1 (almost full at grant)",
                     $time);
         end
      end
      af_last = tx_almost_full;
   end

   always @(negedge clk) begin
      if (bp_on) begin
         tx_almost_full = ($urandom_range(1, 0) == 1);
      end else begin
         tx_almost_full = 1'b0;
      end
   end

   // ======================================================================
   // Helpers
   // ======================================================================

   task automatic write_csr(input csr_addr_e addr, input logic [31:0] data);
      @(negedge clk);
      csr_write = 1'b1;
      csr_addr  = addr;
      csr_data  = data;
      @(negedge clk);
      csr_write = 1'b0;
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // Takes the oldest frame off the queue and compares every field
   task automatic expect_frame(input string what, input logic [31:0] addr,
                               input logic [line_width-1:0] data);
      tx_req_t f;
      int      waited;
      bit      found;
      waited = 0;
      while (frames.size() == 0 && waited < frame_wait) begin
         @(negedge clk);
         waited++;
      end
      found = (frames.size() > 0);
      checks++;
      assert (found) else begin
         errors++;
         $display("Missing frame: no %s arrived within %0d cycles", what, frame_wait);
      end
      if (found) begin
         f = frames.pop_front();
         check_word("tx_req.req_type", 32'(wr_line), 32'(f.write_header.req_type));
         check_word("tx_req.address", addr, f.write_header.address);
         for (int i = 0; i < line_words; i++) begin
            check_word($sformatf("tx_req.data word %0d", i), data[i*32 +: 32],
                       f.data[i*32 +: 32]);
         end
      end
   endtask

   // No frame may arrive within the given number of cycles
   task automatic expect_quiet(input int cycles, input string after);
      repeat (cycles) @(negedge clk);
      checks++;
      assert (frames.size() == 0) else begin
         errors++;
         $display("Unexpected frames: %0d extra after %s", frames.size(), after);
      end
      frames.delete();
   endtask

   task automatic expect_id_line();
      logic [line_width-1:0] exp;
      exp = '0;
      for (int i = 0; i < 4; i++) begin
         exp[i*32 +: 32] = afu_id_base + 32'(i);
      end
      expect_frame("ID line", dsm_base, exp);
   endtask

   // Programs a run, then expects its lines in order and the completion line
   task automatic run_stream(input int len, input bit trigger_in_run);
      logic [line_width-1:0] exp;
      stream_base = $urandom;
      write_csr(csr_stream_base, stream_base);
      write_csr(csr_stream_len, 32'(len));
      write_csr(csr_start, 32'h0);
      if (trigger_in_run) begin
         write_csr(csr_trigger_debug, 32'd3);
      end
      for (int k = 0; k < len; k++) begin
         exp = {line_words{32'(k)}};
         expect_frame($sformatf("stream line %0d", k), stream_base + 32'(k), exp);
      end
      exp = '0;
      exp[31:0]  = 32'd1;
      exp[63:32] = 32'(len);
      expect_frame("completion line", dsm_base + 32'd1, exp);
   endtask

   // ======================================================================
   // Directed tests
   // ======================================================================

   task automatic id_line_after_reset();
      expect_quiet(20, "reset with no DSM base");
      dsm_base = $urandom;
      write_csr(csr_dsm_base, dsm_base);
      expect_id_line();
      expect_quiet(20, "the ID line");
   endtask

   task automatic stream_lines();
      run_stream(len_a, 1'b0);
      expect_quiet(20, "the first stream");
   endtask

   task automatic debug_dump();
      logic [line_width-1:0] exp;
      logic [15:0]           new_len;
      new_len = 16'(len_a + 5);
      exp = '0;
      exp[15*32 +: 32] = 32'd3;
      write_csr(csr_trigger_debug, 32'd3);
      expect_frame("debug line for index 3", dsm_base, exp);
      // A new length while idle keeps lines_written and stream_len apart
      write_csr(csr_stream_len, 32'(new_len));
      // The stream debug word packs lines_written above stream_len
      exp = '0;
      exp[15*32 +: 32] = 32'd1;
      exp[31:0]        = {new_len, 16'h0000};
      exp[63:32]       = 32'(len_a);
      write_csr(csr_trigger_debug, 32'd1);
      expect_frame("debug line for index 1", dsm_base, exp);
      expect_quiet(20, "the debug lines");
   endtask

   task automatic stream_under_back_pressure();
      bp_on = 1'b1;
      run_stream(len_b, 1'b0);
      bp_on = 1'b0;
      expect_quiet(20, "the back-pressured stream");
   endtask

   task automatic ignored_requests();
      write_csr(csr_stream_len, 32'd0);
      write_csr(csr_start, 32'h0);
      expect_quiet(30, "a start with zero length");
      // The debug trigger lands while the FSM is in its run state
      run_stream(len_c, 1'b1);
      expect_quiet(30, "a trigger during a run");
   endtask

   task automatic reset_mid_run();
      int waited;
      waited = 0;
      stream_base = $urandom;
      write_csr(csr_stream_base, stream_base);
      write_csr(csr_stream_len, 32'(len_d));
      write_csr(csr_start, 32'h0);
      while (frames.size() < 3 && waited < frame_wait) begin
         @(negedge clk);
         waited++;
      end
      checks++;
      assert (frames.size() >= 3) else begin
         errors++;
         $display("Stream did not start before the mid-run reset");
      end
      resetb = 1'b0;
      // The stream lines seen before the reset are not compared here
      @(negedge clk);
      frames.delete();
      repeat (9) @(negedge clk);
      resetb = 1'b1;
      expect_quiet(30, "a reset in the middle of a run");
      dsm_base = $urandom;
      write_csr(csr_dsm_base, dsm_base);
      expect_id_line();
      expect_quiet(20, "the ID line after reset");
   endtask

   // ======================================================================
   // Main sequence and watchdog
   // ======================================================================

   initial begin
      void'($urandom(32'h6bde));
      resetb         = 1'b0;
      csr_write      = 1'b0;
      csr_addr       = csr_dsm_base;
      csr_data       = '0;
      tx_almost_full = 1'b0;
      bp_on          = 1'b0;
      af_last        = 1'b0;
      errors         = 0;
      checks         = 0;
      dsm_base       = '0;
      stream_base    = '0;
      len_a          = $urandom_range(20, 1);
      len_b          = $urandom_range(20, 1);
      len_c          = $urandom_range(20, 1);
      // Long enough that the reset falls well inside the run
      len_d          = $urandom_range(20, 10);
      budget = 10 + num_tests * 200 + 4 * (len_a + len_b + len_c + len_d);

      fork
         begin
            #(budget * clk_period);
            $display("Timeout: the run did not finish within %0d cycles", budget);
            $display("tests failed");
            $finish;
         end
      join_none

      repeat (10) @(negedge clk);
      resetb = 1'b1;

      id_line_after_reset();
      stream_lines();
      debug_dump();
      stream_under_back_pressure();
      ignored_requests();
      reset_mid_run();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- sources.f
verilog/qa_pkg.sv
verilog/qa_csr.sv
verilog/status_writer.sv
verilog/stream_writer.sv
verilog/tx_write_arbiter.sv
verilog/qa_afu_top.sv
test/tb_clock.sv
test/qa_afu_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0 -Wno-fatal
TOP       := qa_afu_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
